// File: design/sdram_cfg.svh
`ifndef SDRAM_CFG_SVH
`define SDRAM_CFG_SVH

// SDRAM timing in clock cycles

// Row cycle time, used between the init refreshes
`define SDRAM_T_RC    9
// Precharge to activate
`define SDRAM_T_RP    3
// Activate to read or write
`define SDRAM_T_RCD   3
// Mode register set to the next command
`define SDRAM_T_MRD   2
// Last write data to precharge
`define SDRAM_T_DPL   2
// Power-up wait before the first precharge
`define SDRAM_T_INIT  14250
// Spacing between periodic refreshes
`define SDRAM_T_REF   1114

// Mode register contents
`define SDRAM_CAS     sdram_cmd_pkg::CAS_3
`define SDRAM_BURST   sdram_cmd_pkg::BURST_8

`endif

// File: design/sdram_cmd_pkg.sv
package sdram_cmd_pkg;

    // Commands as seen on the controller command port
    typedef enum logic [2:0] {
        OP_NOP = 3'd0,
        OP_ACT = 3'd1,
        OP_RD  = 3'd2,
        OP_WR  = 3'd3,
        OP_PRE = 3'd4,
        OP_REF = 3'd5,
        OP_MRS = 3'd6
    } op_t;

    // CAS latency field of the mode register
    typedef enum logic [2:0] {
        CAS_2 = 3'd2,
        CAS_3 = 3'd3
    } cas_t;

    // Burst length field of the mode register
    typedef enum logic [2:0] {
        BURST_1 = 3'd0,
        BURST_2 = 3'd1,
        BURST_4 = 3'd2,
        BURST_8 = 3'd3
    } burst_t;

    // addr holds the row for ACT and the column for RD and WR
    typedef struct packed {
        op_t         op;
        logic [1:0]  bank;
        logic [14:0] addr;
        logic [15:0] data;
    } cmd_t;

    // Set in addr of a PRE to close all banks
    localparam int PALL_BIT = 10;

endpackage

// File: design/sdram_host_pkg.sv
package sdram_host_pkg;

    typedef enum logic [0:0] {
        ACC_READ  = 1'b0,
        ACC_WRITE = 1'b1
    } access_t;

    // One host access, held by the host while host_req is high
    typedef struct packed {
        access_t     kind;
        logic [1:0]  bank;
        logic [12:0] row;
        logic [9:0]  col;
        logic [15:0] wdata;
    } host_req_t;

endpackage

// File: design/sdram_init_refresh.sv
`timescale 1ns/1ps
`include "sdram_cfg.svh"

module sdram_init_refresh
    import sdram_cmd_pkg::*;
(
    input  logic CLK,
    input  logic RESET_IN,
    input  logic bank_active,
    output logic init_done,
    output cmd_t cmd,
    output logic cmd_req,
    input  logic cmd_ack
);

    localparam int INIT_TOTAL = `SDRAM_T_INIT + `SDRAM_T_RP + 2 * `SDRAM_T_RC + `SDRAM_T_MRD;
    localparam int CNT_W = $clog2(INIT_TOTAL);

    localparam logic [CNT_W-1:0] INIT_LOAD = CNT_W'(INIT_TOTAL - 1);
    localparam logic [CNT_W-1:0] REF_LOAD  = CNT_W'(`SDRAM_T_REF - 1);

    // Counter values at which the init commands are placed
    localparam logic [CNT_W-1:0] AT_PALL =
        CNT_W'(`SDRAM_T_MRD + 2 * `SDRAM_T_RC + `SDRAM_T_RP - 1);
    localparam logic [CNT_W-1:0] AT_REF1 = CNT_W'(`SDRAM_T_MRD + 2 * `SDRAM_T_RC - 1);
    localparam logic [CNT_W-1:0] AT_REF2 = CNT_W'(`SDRAM_T_MRD + `SDRAM_T_RC - 1);
    localparam logic [CNT_W-1:0] AT_MRS  = CNT_W'(`SDRAM_T_MRD - 1);

    localparam cas_t        CAS_CODE   = `SDRAM_CAS;
    localparam burst_t      BURST_CODE = `SDRAM_BURST;
    localparam logic [14:0] MODE_WORD  = {8'b0, CAS_CODE, 1'b0, BURST_CODE};

    typedef enum logic [1:0] {REF_NOP, REF_PRE, REF_REF} ref_state_t;

    logic [CNT_W-1:0] cnt;
    ref_state_t       ref_state;

    // Counts down the init sequence once, then runs as the refresh timer
    always_ff @(posedge CLK or posedge RESET_IN) begin
        if (RESET_IN) begin
            cnt <= INIT_LOAD;
        end else if (cnt == '0) begin
            cnt <= REF_LOAD;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge CLK or posedge RESET_IN) begin
        if (RESET_IN) begin
            init_done <= 1'b0;
        end else if (cnt == '0) begin
            init_done <= 1'b1;
        end
    end

    // A new tick overrides a pending request, so refreshes never pile up
    always_ff @(posedge CLK or posedge RESET_IN) begin
        if (RESET_IN) begin
            ref_state <= REF_NOP;
        end else if (init_done && cnt == '0) begin
            ref_state <= bank_active ? REF_PRE : REF_REF;
        end else if (init_done && cmd_req && cmd_ack) begin
            ref_state <= (ref_state == REF_PRE) ? REF_REF : REF_NOP;
        end
    end

    always_comb begin
        cmd     = '0;
        cmd_req = !init_done || ref_state != REF_NOP;
        if (!init_done) begin
            if (cnt == AT_PALL) begin
                cmd.op             = OP_PRE;
                cmd.addr[PALL_BIT] = 1'b1;
            end else if (cnt == AT_REF1 || cnt == AT_REF2) begin
                cmd.op = OP_REF;
            end else if (cnt == AT_MRS) begin
                cmd.op   = OP_MRS;
                cmd.data = {1'b0, MODE_WORD};
            end
        end else if (ref_state == REF_PRE) begin
            cmd.op             = OP_PRE;
            cmd.addr[PALL_BIT] = 1'b1;
        end else if (ref_state == REF_REF) begin
            cmd.op = OP_REF;
        end
    end

    // A periodic REF may only be accepted once every bank is closed
    a_ref_when_closed: assert property (@(posedge CLK) disable iff (RESET_IN)
        init_done && cmd_req && cmd_ack && cmd.op == OP_REF |-> !bank_active);

endmodule

// File: design/sdram_access_seq.sv
`timescale 1ns/1ps
`include "sdram_cfg.svh"

module sdram_access_seq
    import sdram_cmd_pkg::*, sdram_host_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET_IN,
    input  logic      host_req,
    input  host_req_t host_data,
    output logic      host_ack,
    output cmd_t      cmd,
    output logic      cmd_req,
    input  logic      cmd_ack
);

    // The wait states already cover two cycles of each gap
    localparam int RCD_WAIT = `SDRAM_T_RCD - 2;
    localparam int DPL_WAIT = `SDRAM_T_DPL - 2;
    localparam int RP_WAIT  = `SDRAM_T_RP - 2;
    localparam int WAIT_MAX = (RCD_WAIT > DPL_WAIT) ?
        ((RCD_WAIT > RP_WAIT) ? RCD_WAIT : RP_WAIT) :
        ((DPL_WAIT > RP_WAIT) ? DPL_WAIT : RP_WAIT);
    localparam int SPC_W = $clog2(WAIT_MAX + 2);

    typedef enum logic [2:0] {
        IDLE, ACT, WAIT_RCD, RW, WAIT_DPL, PRE, WAIT_RP, ACK
    } state_t;

    state_t           state;
    logic [SPC_W-1:0] spc_cnt;
    host_req_t        req_q;

    always_ff @(posedge CLK or posedge RESET_IN) begin
        if (RESET_IN) begin
            state   <= IDLE;
            spc_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (host_req) state <= ACT;
                end
                ACT: begin
                    if (cmd_ack) begin
                        state   <= WAIT_RCD;
                        spc_cnt <= SPC_W'(RCD_WAIT);
                    end
                end
                WAIT_RCD: begin
                    if (spc_cnt == '0) state <= RW;
                    else spc_cnt <= spc_cnt - 1'b1;
                end
                RW: begin
                    if (cmd_ack) begin
                        state   <= WAIT_DPL;
                        spc_cnt <= SPC_W'(DPL_WAIT);
                    end
                end
                WAIT_DPL: begin
                    if (spc_cnt == '0) state <= PRE;
                    else spc_cnt <= spc_cnt - 1'b1;
                end
                PRE: begin
                    if (cmd_ack) begin
                        state   <= WAIT_RP;
                        spc_cnt <= SPC_W'(RP_WAIT);
                    end
                end
                WAIT_RP: begin
                    if (spc_cnt == '0) state <= ACK;
                    else spc_cnt <= spc_cnt - 1'b1;
                end
                default: begin
                    if (!host_req) state <= IDLE;
                end
            endcase
        end
    end

    // Request is latched once so the host fields may change after host_ack
    always_ff @(posedge CLK) begin
        if (state == IDLE && host_req) req_q <= host_data;
    end

    assign host_ack = (state == ACK);
    assign cmd_req  = (state == ACT) || (state == RW) || (state == PRE);

    always_comb begin
        cmd      = '0;
        cmd.bank = req_q.bank;
        case (state)
            ACT: begin
                cmd.op   = OP_ACT;
                cmd.addr = {2'b0, req_q.row};
            end
            RW: begin
                cmd.op   = (req_q.kind == ACC_WRITE) ? OP_WR : OP_RD;
                cmd.addr = {5'b0, req_q.col};
                if (req_q.kind == ACC_WRITE) cmd.data = req_q.wdata;
            end
            PRE: cmd.op = OP_PRE;
            default: cmd.op = OP_NOP;
        endcase
    end

    a_cmd_hold: assert property (@(posedge CLK) disable iff (RESET_IN)
        cmd_req && !cmd_ack |=> cmd_req && $stable(cmd));

endmodule

// File: design/sdram_cmd_arbiter.sv
`timescale 1ns/1ps

module sdram_cmd_arbiter
    import sdram_cmd_pkg::*;
(
    input  logic CLK,
    input  logic RESET_IN,
    input  logic init_done,

    input  cmd_t ref_cmd,
    input  logic ref_req,
    output logic ref_ack,

    input  cmd_t acc_cmd,
    input  logic acc_req,
    output logic acc_ack,

    output cmd_t cmd,
    output logic cmd_req,
    input  logic cmd_ack,

    output logic bank_active
);

    logic lock;
    logic grant_ref;
    logic acc_xfer;

    // Refresh owns the port during init and wins whenever no bank is open
    assign grant_ref = !init_done || (ref_req && !lock);

    assign cmd     = grant_ref ? ref_cmd : acc_cmd;
    assign cmd_req = grant_ref ? ref_req : acc_req;
    assign ref_ack = grant_ref && cmd_ack;
    assign acc_ack = !grant_ref && cmd_ack;

    assign acc_xfer = acc_req && acc_ack;

    // The bank stays open from the access ACT until its PRE
    always_ff @(posedge CLK or posedge RESET_IN) begin
        if (RESET_IN) begin
            lock <= 1'b0;
        end else if (acc_xfer && acc_cmd.op == OP_ACT) begin
            lock <= 1'b1;
        end else if (acc_xfer && acc_cmd.op == OP_PRE) begin
            lock <= 1'b0;
        end
    end

    assign bank_active = lock;

    // An access opens a bank only when none is open, and closes only an open one
    a_act_when_free: assert property (@(posedge CLK) disable iff (RESET_IN)
        acc_xfer && acc_cmd.op == OP_ACT |-> !lock);

    a_pre_when_locked: assert property (@(posedge CLK) disable iff (RESET_IN)
        acc_xfer && acc_cmd.op == OP_PRE |-> lock);

endmodule

// File: design/sdram_ctrl_top.sv
`timescale 1ns/1ps

module sdram_ctrl_top
    import sdram_cmd_pkg::*, sdram_host_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET_IN,
    input  logic      host_req,
    input  host_req_t host_data,
    output logic      host_ack,
    output logic      init_done,
    output cmd_t      cmd,
    output logic      cmd_req,
    input  logic      cmd_ack
);

    cmd_t ref_cmd;
    logic ref_req;
    logic ref_ack;
    cmd_t acc_cmd;
    logic acc_req;
    logic acc_ack;
    logic bank_active;

    sdram_init_refresh u_init_refresh (
        .CLK         (CLK),
        .RESET_IN    (RESET_IN),
        .bank_active (bank_active),
        .init_done   (init_done),
        .cmd         (ref_cmd),
        .cmd_req     (ref_req),
        .cmd_ack     (ref_ack)
    );

    sdram_access_seq u_access_seq (
        .CLK       (CLK),
        .RESET_IN  (RESET_IN),
        .host_req  (host_req),
        .host_data (host_data),
        .host_ack  (host_ack),
        .cmd       (acc_cmd),
        .cmd_req   (acc_req),
        .cmd_ack   (acc_ack)
    );

    sdram_cmd_arbiter u_cmd_arbiter (
        .CLK         (CLK),
        .RESET_IN    (RESET_IN),
        .init_done   (init_done),
        .ref_cmd     (ref_cmd),
        .ref_req     (ref_req),
        .ref_ack     (ref_ack),
        .acc_cmd     (acc_cmd),
        .acc_req     (acc_req),
        .acc_ack     (acc_ack),
        .cmd         (cmd),
        .cmd_req     (cmd_req),
        .cmd_ack     (cmd_ack),
        .bank_active (bank_active)
    );

endmodule

// File: test/sdram_ctrl_tb.sv
`timescale 1ns/1ps
`include "sdram_cfg.svh"

module sdram_ctrl_tb
    import sdram_cmd_pkg::*, sdram_host_pkg::*;
();

    localparam int INIT_TOTAL = `SDRAM_T_INIT + `SDRAM_T_RP + 2 * `SDRAM_T_RC + `SDRAM_T_MRD;
    localparam int T_REF      = `SDRAM_T_REF;
    localparam int ACC_LIMIT  = 2000;

    logic      CLK;
    logic      RESET_IN;
    logic      host_req;
    host_req_t host_data;
    logic      host_ack;
    logic      init_done;
    cmd_t      cmd;
    logic      cmd_req;
    logic      cmd_ack = 1'b1;

    integer seed       = 32'hbea;
    integer stall_seed = 32'hbea;
    int     cyc        = 0;
    int     done_cyc   = 0;
    int     ref_seen   = 0;
    int     val_err    = 0;
    int     oth_err    = 0;
    bit     aborted    = 1'b0;
    bit     stall_en   = 1'b0;

    // Every accepted non-NOP command and the clock edge it transferred on
    cmd_t log_cmd[$];
    int   log_cyc[$];

    sdram_ctrl_top UUT (
        .CLK       (CLK),
        .RESET_IN  (RESET_IN),
        .host_req  (host_req),
        .host_data (host_data),
        .host_ack  (host_ack),
        .init_done (init_done),
        .cmd       (cmd),
        .cmd_req   (cmd_req),
        .cmd_ack   (cmd_ack)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // The sink stalls about one cycle in four once stalls are enabled
    always @(negedge CLK) begin
        if (init_done && stall_en) begin
            cmd_ack <= ($random(stall_seed) % 4) != 0;
        end else begin
            cmd_ack <= 1'b1;
        end
    end

    always @(posedge CLK) begin
        if (!RESET_IN) begin
            cyc = cyc + 1;
            // init_done is first seen one edge after the edge that set it
            if (init_done && done_cyc == 0) done_cyc = cyc - 1;
            if (!init_done) begin
                assert (cmd_req && cmd_ack) else begin
                    oth_err++;
                    $display("Command port did not transfer during init at cycle %0d", cyc);
                end
            end
            if (cmd_req && cmd_ack && cmd.op != OP_NOP) begin
                log_cmd.push_back(cmd);
                log_cyc.push_back(cyc);
            end
        end
    end

    function automatic logic [15:0] mode_word();
        cas_t   cas_code;
        burst_t burst_code;
        cas_code   = `SDRAM_CAS;
        burst_code = `SDRAM_BURST;
        return {9'b0, cas_code, 1'b0, burst_code};
    endfunction

    // Expected command for step 0 (ACT), 1 (RD or WR) and 2 (PRE) of a host access
    function automatic cmd_t expect_access(host_req_t r, int step);
        cmd_t c;
        c      = '0;
        c.bank = r.bank;
        if (step == 0) begin
            c.op   = OP_ACT;
            c.addr = {2'b00, r.row};
        end else if (step == 1) begin
            c.addr = {5'b0, r.col};
            c.op   = (r.kind == ACC_WRITE) ? OP_WR : OP_RD;
            if (r.kind == ACC_WRITE) c.data = r.wdata;
        end else begin
            c.op = OP_PRE;
        end
        return c;
    endfunction

    function automatic bit is_refresh(cmd_t c);
        return (c.op == OP_REF) || (c.op == OP_PRE && c.addr[PALL_BIT]);
    endfunction

    task automatic take_entry(output cmd_t c, output int c_cyc);
        c     = log_cmd.pop_front();
        c_cyc = log_cyc.pop_front();
        if (c.op == OP_REF && c_cyc > INIT_TOTAL) ref_seen++;
    endtask

    task automatic note_timeout(input string what);
        oth_err++;
        aborted = 1'b1;
        $display("Timeout while waiting for %s", what);
    endtask

    // Compares the oldest transfer with a command at a fixed clock edge
    task automatic expect_next(input cmd_t exp, input int exp_cyc, input string what);
        cmd_t got;
        int   got_cyc;
        if (log_cmd.size() == 0) begin
            oth_err++;
            $display("%s never transferred", what);
        end else begin
            take_entry(got, got_cyc);
            assert (got == exp && got_cyc == exp_cyc) else begin
                val_err++;
                $display("Fail at %0t: %s got %h at cycle %0d, expected %h at cycle %0d",
                         $time, what, got, got_cyc, exp, exp_cyc);
            end
        end
    endtask

    task automatic check_init();
        cmd_t exp;
        int   at_cnt [4];
        if (!aborted) begin
            at_cnt[0] = `SDRAM_T_MRD + 2 * `SDRAM_T_RC + `SDRAM_T_RP - 1;
            at_cnt[1] = `SDRAM_T_MRD + 2 * `SDRAM_T_RC - 1;
            at_cnt[2] = `SDRAM_T_MRD + `SDRAM_T_RC - 1;
            at_cnt[3] = `SDRAM_T_MRD - 1;
            assert (done_cyc == INIT_TOTAL) else begin
                val_err++;
                $display("Fail at %0t: init_done rose at cycle %0d, expected %0d",
                         $time, done_cyc, INIT_TOTAL);
            end
            for (int i = 0; i < 4; i++) begin
                exp = '0;
                if (i == 0) begin
                    exp.op             = OP_PRE;
                    exp.addr[PALL_BIT] = 1'b1;
                end else if (i == 3) begin
                    exp.op   = OP_MRS;
                    exp.data = mode_word();
                end else begin
                    exp.op = OP_REF;
                end
                // The counter reads INIT_TOTAL minus the edge number
                expect_next(exp, INIT_TOTAL - at_cnt[i], $sformatf("Init command %0d", i));
            end
            assert (log_cmd.size() == 0) else begin
                oth_err++;
                $display("Extra commands transferred during init");
            end
        end
    endtask

    task automatic check_access(input host_req_t r, input int n);
        cmd_t got;
        int   got_cyc;
        int   step;
        step = 0;
        while (step < 3 && log_cmd.size() > 0) begin
            take_entry(got, got_cyc);
            if (is_refresh(got)) begin
                assert (step == 0) else begin
                    oth_err++;
                    $display("Refresh command inside access %0d at cycle %0d", n, got_cyc);
                end
            end else begin
                assert (got == expect_access(r, step)) else begin
                    val_err++;
                    $display("Fail at %0t: access %0d step %0d got %h, expected %h",
                             $time, n, step, got, expect_access(r, step));
                end
                step++;
            end
        end
        assert (step == 3) else begin
            oth_err++;
            $display("Access %0d finished with only %0d of 3 commands transferred", n, step);
        end
    endtask

    task automatic run_access(input host_req_t r, input int n);
        int t;
        if (!aborted) begin
            @(negedge CLK);
            host_data = r;
            host_req  = 1'b1;
            t = 0;
            while (!host_ack && t < ACC_LIMIT) begin
                @(negedge CLK);
                t++;
            end
            if (!host_ack) begin
                note_timeout($sformatf("host_ack of access %0d", n));
            end else begin
                host_req = 1'b0;
                t = 0;
                while (host_ack && t < ACC_LIMIT) begin
                    @(negedge CLK);
                    t++;
                end
                if (host_ack) note_timeout($sformatf("host_ack release of access %0d", n));
                else check_access(r, n);
            end
        end
    endtask

    task automatic wait_cycle(input int target, input string what);
        int t;
        t = 0;
        while (!aborted && cyc < target && t < target + 10) begin
            @(negedge CLK);
            t++;
        end
        if (!aborted && cyc < target) note_timeout(what);
    endtask

    // Waits until the refresh timer is at the given point of its period
    task automatic wait_phase(input int phase);
        int t;
        t = 0;
        while (!aborted && (cyc - INIT_TOTAL) % T_REF != phase && t < T_REF + 4) begin
            @(negedge CLK);
            t++;
        end
        if (!aborted && (cyc - INIT_TOTAL) % T_REF != phase) note_timeout("refresh phase");
    endtask

    initial begin
        host_req_t r;
        cmd_t      exp;
        cmd_t      got;
        int        got_cyc;
        RESET_IN  = 1'b1;
        host_req  = 1'b0;
        host_data = '0;
        repeat (3) @(negedge CLK);
        RESET_IN = 1'b0;

        wait_cycle(INIT_TOTAL + 1, "init_done");
        check_init();

        wait_cycle(INIT_TOTAL + 3 * T_REF + T_REF / 2, "three refresh periods");
        for (int k = 1; k <= 3 && !aborted; k++) begin
            exp    = '0;
            exp.op = OP_REF;
            expect_next(exp, INIT_TOTAL + k * T_REF + 1, $sformatf("Periodic REF %0d", k));
        end

        r.kind  = ACC_WRITE;
        r.bank  = 2'd2;
        r.row   = 13'h1abc;
        r.col   = 10'h2a5;
        r.wdata = 16'hc35a;
        run_access(r, 0);

        for (int n = 1; n <= 28 && !aborted; n++) begin
            stall_en = (n > 12);
            r.kind   = (n % 3 == 0) ? ACC_WRITE : ACC_READ;
            r.bank   = 2'($random(seed));
            r.row    = 13'($random(seed));
            r.col    = 10'($random(seed));
            r.wdata  = 16'($random(seed));
            // Start some accesses just before a refresh tick
            if (n % 4 == 0) wait_phase(T_REF - 1 - int'($unsigned($random(seed)) % 6));
            run_access(r, n);
        end

        stall_en = 1'b0;
        wait_phase(T_REF / 2);
        if (!aborted) begin
            while (log_cmd.size() > 0) begin
                take_entry(got, got_cyc);
                assert (is_refresh(got)) else begin
                    oth_err++;
                    $display("Unexpected command %h after the last access at cycle %0d",
                             got, got_cyc);
                end
            end
            assert (ref_seen == (cyc - INIT_TOTAL) / T_REF) else begin
                val_err++;
                $display("Fail at %0t: %0d refresh REFs seen, expected %0d",
                         $time, ref_seen, (cyc - INIT_TOTAL) / T_REF);
            end
        end

        $display("Errors: %0d value, %0d other", val_err, oth_err);
        if (val_err == 0 && oth_err == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+design
design/sdram_cmd_pkg.sv
design/sdram_host_pkg.sv
design/sdram_init_refresh.sv
design/sdram_access_seq.sv
design/sdram_cmd_arbiter.sv
design/sdram_ctrl_top.sv
test/sdram_ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the SDRAM controller testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f src.f \
    --top-module sdram_ctrl_tb \
    -o sdram_ctrl_sim

./obj_dir/sdram_ctrl_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: pass message not found in sim.log"
    exit 1
fi
